/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
TOP       := tb_load_rotator
RTL_TOP   := load_rotator_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
SRCS      := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+hdl
hdl/rot_pkg.sv
hdl/rot_ctl_stage.sv
hdl/rot_merge_stage.sv
hdl/rot_shift_stage.sv
hdl/load_rotator_top.sv
tests/rot_checker.sv
tests/tb_load_rotator.sv

/* hdl/load_rotator_top.sv */
// Load data rotator top, three-stage valid/ready pipeline from request to aligned data
`timescale 1ns/1ps

module load_rotator_top (
   input  logic               nclk,
   input  logic               rst,
   input  logic               in_valid,
   output logic               in_ready,
   input  rot_pkg::rot_req_t  in_req,
   output logic               out_valid,
   input  logic               out_ready,
   output rot_pkg::rot_data_t out_data
);
   import rot_pkg::*;

   // Stage 1 to stage 2 link
   logic           ctl_valid;
   logic           ctl_ready;
   rot_ctl_req_t   ctl_req;

   // Stage 2 to stage 3 link
   logic           shift_valid;
   logic           shift_ready;
   rot_shift_req_t shift_req;

   // Select decode and size mask
   rot_ctl_stage ctl0 (
      .nclk      (nclk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (ctl_valid),
      .out_ready (ctl_ready),
      .out_req   (ctl_req)
   );

   // Bypass merge and endian swap
   rot_merge_stage merge0 (
      .nclk      (nclk),
      .rst       (rst),
      .in_valid  (ctl_valid),
      .in_ready  (ctl_ready),
      .in_req    (ctl_req),
      .out_valid (shift_valid),
      .out_ready (shift_ready),
      .out_req   (shift_req)
   );

   // Rotate and mask
   rot_shift_stage shift0 (
      .nclk      (nclk),
      .rst       (rst),
      .in_valid  (shift_valid),
      .in_ready  (shift_ready),
      .in_req    (shift_req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

endmodule

/* hdl/rot_consts.svh */
// Load rotator sizing constants shared by the package and the pipeline stages
`ifndef ROT_CONSTS_SVH
`define ROT_CONSTS_SVH

// --------------------------------------------------
// Datapath geometry
// --------------------------------------------------

// Byte lanes across the load data word
`define ROT_LANES 16

// Bits per byte lane
`define ROT_LANE_W 8

// Rotate amount width, upper pair picks 4-byte steps, lower pair 1-byte steps
`define ROT_SEL_W 4

// One-hot access sizes, 16B/8B/4B/2B/1B
`define ROT_SIZES 5

`endif

/* hdl/rot_ctl_stage.sv */
// Load rotator stage 1, decodes the rotate amount and builds the access size lane mask
`timescale 1ns/1ps
`include "rot_consts.svh"

module rot_ctl_stage (
   input  logic                  nclk,
   input  logic                  rst,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  rot_pkg::rot_req_t     in_req,
   output logic                  out_valid,
   input  logic                  out_ready,
   output rot_pkg::rot_ctl_req_t out_req
);
   import rot_pkg::*;

   logic [0:`ROT_SEL_W-1] rot_sel;
   logic [0:`ROT_SIZES-1] size_pfx;
   rot_ctl_t              ctl_d;
   rot_ctl_req_t          req_q;
   logic                  valid_q;

   // --------------------------------------------------
   // Rotate control decode
   // --------------------------------------------------

   // Endian flag picks which rotate amount applies
   assign rot_sel = in_req.le ? in_req.le_rotate_sel : in_req.be_rotate_sel;

   always_comb begin
      ctl_d.le = in_req.le;

      // Upper pair, one-hot over 0/4/8/12 byte steps
      ctl_d.shx04_sel = 4'b0000;
      ctl_d.shx04_sel[rot_sel[0:1]] = 1'b1;

      // Lower pair, one-hot over 0/1/2/3 byte steps
      ctl_d.shx01_sel = 4'b0000;
      ctl_d.shx01_sel[rot_sel[2:3]] = 1'b1;

      // Size prefix OR, bit k set when the load is at least size k
      size_pfx[0] = in_req.size[0];
      for (int k = 1; k < `ROT_SIZES; k++) begin
         size_pfx[k] = size_pfx[k-1] | in_req.size[k];
      end

      // Upper half of the word only for 16B
      ctl_d.lane_mask[0:7] = {8{size_pfx[0]}};
      // 8B and up
      ctl_d.lane_mask[8:11] = {4{size_pfx[1]}};
      // 4B and up
      ctl_d.lane_mask[12:13] = {2{size_pfx[2]}};
      ctl_d.lane_mask[14] = size_pfx[3];
      // Any legal one-hot size keeps the last lane
      ctl_d.lane_mask[15] = size_pfx[4];
   end

   // --------------------------------------------------
   // Stage register and handshake
   // --------------------------------------------------

   // Accept when empty or when the held entry leaves this cycle
   assign in_ready = ~valid_q | out_ready;

   always_ff @(posedge nclk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   // Payload travels with the decoded controls
   always_ff @(posedge nclk) begin
      if (in_valid && in_ready) begin
         req_q.ctl           <= ctl_d;
         req_q.stq_byp_val   <= in_req.stq_byp_val;
         req_q.stq7_byp_val  <= in_req.stq7_byp_val;
         req_q.arr_data      <= in_req.arr_data;
         req_q.stq7_rmw_data <= in_req.stq7_rmw_data;
         req_q.stq8_rmw_data <= in_req.stq8_rmw_data;
      end
   end

   assign out_valid = valid_q;
   assign out_req   = req_q;

endmodule

/* hdl/rot_merge_stage.sv */
// Load rotator stage 2, store queue bypass select and little-endian byte reversal
`timescale 1ns/1ps
`include "rot_consts.svh"

module rot_merge_stage (
   input  logic                    nclk,
   input  logic                    rst,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  rot_pkg::rot_ctl_req_t   in_req,
   output logic                    out_valid,
   input  logic                    out_ready,
   output rot_pkg::rot_shift_req_t out_req
);
   import rot_pkg::*;

   rot_data_t      sel_data;
   rot_data_t      adj_data;
   rot_shift_req_t req_q;
   logic           valid_q;

   // --------------------------------------------------
   // RMW bypass mux and endian swap
   // --------------------------------------------------

   always_comb begin
      // Stage 7 store data is younger, so it wins over stage 8
      if (in_req.stq_byp_val && in_req.stq7_byp_val) begin
         sel_data = in_req.stq7_rmw_data;
      end else if (in_req.stq_byp_val) begin
         sel_data = in_req.stq8_rmw_data;
      end else begin
         sel_data = in_req.arr_data;
      end

      // LE mirrors lanes end to end before rotation
      for (int i = 0; i < `ROT_LANES; i++) begin
         if (in_req.ctl.le) begin
            adj_data[i] = sel_data[`ROT_LANES-1-i];
         end else begin
            adj_data[i] = sel_data[i];
         end
      end
   end

   // --------------------------------------------------
   // Stage register and handshake
   // --------------------------------------------------

   assign in_ready = ~valid_q | out_ready;

   always_ff @(posedge nclk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge nclk) begin
      if (in_valid && in_ready) begin
         req_q.ctl  <= in_req.ctl;
         req_q.data <= adj_data;
      end
   end

   assign out_valid = valid_q;
   assign out_req   = req_q;

endmodule

/* hdl/rot_pkg.sv */
// Load rotator types for the request, decoded controls and inter-stage payloads
`include "rot_consts.svh"

package rot_pkg;

   // One-hot access size, bit 0 is the 16-byte load
   typedef enum logic [0:`ROT_SIZES-1] {
      SIZE_16B = 5'b10000,
      SIZE_8B  = 5'b01000,
      SIZE_4B  = 5'b00100,
      SIZE_2B  = 5'b00010,
      SIZE_1B  = 5'b00001
   } rot_size_e;

   // Lane 0 is the most significant byte
   typedef logic [0:`ROT_LANES-1][`ROT_LANE_W-1:0] rot_data_t;

   // Load request as presented by the LSU
   typedef struct packed {
      rot_size_e             size;
      logic                  le;
      logic [0:`ROT_SEL_W-1] be_rotate_sel;
      logic [0:`ROT_SEL_W-1] le_rotate_sel;
      logic                  stq_byp_val;
      logic                  stq7_byp_val;
      rot_data_t             arr_data;
      rot_data_t             stq7_rmw_data;
      rot_data_t             stq8_rmw_data;
   } rot_req_t;

   // Decoded rotate and mask controls
   typedef struct packed {
      logic                  le;
      logic [0:3]            shx04_sel;
      logic [0:3]            shx01_sel;
      logic [0:`ROT_LANES-1] lane_mask;
   } rot_ctl_t;

   // Stage 1 output, controls plus the raw data candidates
   typedef struct packed {
      rot_ctl_t  ctl;
      logic      stq_byp_val;
      logic      stq7_byp_val;
      rot_data_t arr_data;
      rot_data_t stq7_rmw_data;
      rot_data_t stq8_rmw_data;
   } rot_ctl_req_t;

   // Stage 2 output, controls plus merged endian-adjusted data
   typedef struct packed {
      rot_ctl_t  ctl;
      rot_data_t data;
   } rot_shift_req_t;

endpackage

/* hdl/rot_shift_stage.sv */
// Load rotator stage 3, two-level byte rotate right with access size lane masking
`timescale 1ns/1ps
`include "rot_consts.svh"

module rot_shift_stage (
   input  logic                    nclk,
   input  logic                    rst,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  rot_pkg::rot_shift_req_t in_req,
   output logic                    out_valid,
   input  logic                    out_ready,
   output rot_pkg::rot_data_t      out_data
);
   import rot_pkg::*;

   rot_data_t mx1;
   rot_data_t mx2;
   rot_data_t data_q;
   logic      valid_q;

   // --------------------------------------------------
   // First mux level, 0/4/8/12 lanes
   // --------------------------------------------------

   // AND-OR mux, selects are one-hot so exactly one term survives
   always_comb begin
      for (int i = 0; i < `ROT_LANES; i++) begin
         mx1[i] = '0;
         for (int s = 0; s < 4; s++) begin
            if (in_req.ctl.shx04_sel[s]) begin
               // Rotate right, lane i pulls from the lane 4*s below it
               mx1[i] = mx1[i] | in_req.data[(i - 4*s + `ROT_LANES) % `ROT_LANES];
            end
         end
      end
   end

   // --------------------------------------------------
   // Second mux level, 0/1/2/3 lanes with mask
   // --------------------------------------------------

   // Lane mask gates the selects, a masked lane has no select and reads zero
   always_comb begin
      for (int i = 0; i < `ROT_LANES; i++) begin
         mx2[i] = '0;
         for (int s = 0; s < 4; s++) begin
            if (in_req.ctl.shx01_sel[s] && in_req.ctl.lane_mask[i]) begin
               mx2[i] = mx2[i] | mx1[(i - s + `ROT_LANES) % `ROT_LANES];
            end
         end
      end
   end

   // --------------------------------------------------
   // Output register and handshake
   // --------------------------------------------------

   assign in_ready = ~valid_q | out_ready;

   always_ff @(posedge nclk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   // Rotated data held until the consumer takes it
   always_ff @(posedge nclk) begin
      if (in_valid && in_ready) begin
         data_q <= mx2;
      end
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

endmodule

/* tests/rot_checker.sv */
// Load rotator output monitor, in-order compare against golden data with handshake timing checks
`timescale 1ns/1ps

module rot_checker (
   input  logic               nclk,
   input  logic               rst,
   input  logic               in_valid,
   input  logic               in_ready,
   input  logic               out_valid,
   input  logic               out_ready,
   input  rot_pkg::rot_data_t out_data,
   input  logic               check_latency,
   output int                 data_errs,
   output int                 proto_errs,
   output int                 out_count,
   output int                 pending
);
   import rot_pkg::*;

   // Edges from input acceptance to output transfer with no stalls
   localparam int LATENCY = 3;

   rot_data_t exp_q[$];
   string     name_q[$];
   int        accept_q[$];
   int        cyc = 0;
   int        n_data = 0;
   int        n_proto = 0;
   int        n_out = 0;
   int        n_pend = 0;
   logic      seen_accept = 1'b0;

   assign data_errs  = n_data;
   assign proto_errs = n_proto;
   assign out_count  = n_out;
   assign pending    = n_pend;

   // Queued in drive order, so pops follow input order
   task automatic add_expect(input string name, input rot_data_t value);
      name_q.push_back(name);
      exp_q.push_back(value);
      n_pend++;
   endtask

   // --------------------------------------------------
   // Handshake monitor, sampled on the transfer edge
   // --------------------------------------------------

   always @(posedge nclk) begin
      rot_data_t exp_v;
      string     name_v;
      int        t_acc;
      if (!rst) begin
         cyc++;
         // Nothing may leave before the first request goes in
         if (out_valid !== 1'b0 && !seen_accept) begin
            $display("out_valid went high at cycle %0d before any request was accepted", cyc);
            n_proto++;
         end
         if (out_valid && out_ready) begin
            n_out++;
            if (exp_q.size() == 0) begin
               $display("Extra output %h at cycle %0d with no request left to match", out_data,
                        cyc);
               n_proto++;
            end else begin
               exp_v  = exp_q.pop_front();
               name_v = name_q.pop_front();
               n_pend--;
               if (out_data !== exp_v) begin
                  $display("** Error %s: expected %h, actual %h", name_v, exp_v, out_data);
                  n_data++;
               end
               if (accept_q.size() == 0) begin
                  $display("Request %s came out at cycle %0d before it was accepted", name_v,
                           cyc);
                  n_proto++;
               end else begin
                  t_acc = accept_q.pop_front();
                  // Only meaningful while out_ready is held high
                  if (check_latency && (cyc - t_acc != LATENCY)) begin
                     $display("Request %s came out %0d cycles after acceptance instead of %0d",
                              name_v, cyc - t_acc, LATENCY);
                     n_proto++;
                  end
               end
            end
         end
         if (in_valid && in_ready) begin
            accept_q.push_back(cyc);
            seen_accept = 1'b1;
         end
      end
   end

endmodule

/* tests/rot_golden.txt */
# name size le be_sel le_sel stq_byp stq7_byp arr_data stq7_rmw_data stq8_rmw_data expected
# All fields hex, size one-hot 10=16B 08=8B 04=4B 02=2B 01=1B, lane 0 is the leftmost byte
be16_r0 10 0 0 f 0 0 00112233445566778899aabbccddeeff dead beef 00112233445566778899aabbccddeeff
be16_r1 10 0 1 e 0 0 00112233445566778899aabbccddeeff dead beef ff00112233445566778899aabbccddee
be16_r2 10 0 2 d 0 0 00112233445566778899aabbccddeeff dead beef eeff00112233445566778899aabbccdd
be16_r3 10 0 3 c 0 0 00112233445566778899aabbccddeeff dead beef ddeeff00112233445566778899aabbcc
be16_r4 10 0 4 b 0 0 00112233445566778899aabbccddeeff dead beef ccddeeff00112233445566778899aabb
be16_r5 10 0 5 a 0 0 00112233445566778899aabbccddeeff dead beef bbccddeeff00112233445566778899aa
be16_r6 10 0 6 9 0 0 00112233445566778899aabbccddeeff dead beef aabbccddeeff00112233445566778899
be16_r7 10 0 7 8 0 0 00112233445566778899aabbccddeeff dead beef 99aabbccddeeff001122334455667788
be16_r8 10 0 8 7 0 0 00112233445566778899aabbccddeeff dead beef 8899aabbccddeeff0011223344556677
be16_r9 10 0 9 6 0 0 00112233445566778899aabbccddeeff dead beef 778899aabbccddeeff00112233445566
be16_r10 10 0 a 5 0 0 00112233445566778899aabbccddeeff dead beef 66778899aabbccddeeff001122334455
be16_r11 10 0 b 4 0 0 00112233445566778899aabbccddeeff dead beef 5566778899aabbccddeeff0011223344
be16_r12 10 0 c 3 0 0 00112233445566778899aabbccddeeff dead beef 445566778899aabbccddeeff00112233
be16_r13 10 0 d 2 0 0 00112233445566778899aabbccddeeff dead beef 33445566778899aabbccddeeff001122
be16_r14 10 0 e 1 0 0 00112233445566778899aabbccddeeff dead beef 2233445566778899aabbccddeeff0011
be16_r15 10 0 f 0 0 0 00112233445566778899aabbccddeeff dead beef 112233445566778899aabbccddeeff00
le16_r0 10 1 f 0 0 0 00112233445566778899aabbccddeeff dead beef ffeeddccbbaa99887766554433221100
le16_r3 10 1 c 3 0 0 00112233445566778899aabbccddeeff dead beef 221100ffeeddccbbaa99887766554433
le16_r8 10 1 7 8 0 0 00112233445566778899aabbccddeeff dead beef 7766554433221100ffeeddccbbaa9988
le16_r13 10 1 2 d 0 0 00112233445566778899aabbccddeeff dead beef ccbbaa99887766554433221100ffeedd
sz8_r8 08 0 8 5 0 0 00112233445566778899aabbccddeeff dead beef 00000000000000000011223344556677
sz8_r0 08 0 0 5 0 0 00112233445566778899aabbccddeeff dead beef 00000000000000008899aabbccddeeff
sz4_r4 04 0 4 0 0 0 00112233445566778899aabbccddeeff dead beef 0000000000000000000000008899aabb
sz4_r12 04 0 c 0 0 0 00112233445566778899aabbccddeeff dead beef 00000000000000000000000000112233
sz2_r2 02 0 2 0 0 0 00112233445566778899aabbccddeeff dead beef 0000000000000000000000000000ccdd
sz2_r7 02 0 7 0 0 0 00112233445566778899aabbccddeeff dead beef 00000000000000000000000000007788
sz1_r1 01 0 1 0 0 0 00112233445566778899aabbccddeeff dead beef 000000000000000000000000000000ee
sz1_r10 01 0 a 0 0 0 00112233445566778899aabbccddeeff dead beef 00000000000000000000000000000055
le_sz4_r3 04 1 0 3 0 0 00112233445566778899aabbccddeeff dead beef 00000000000000000000000066554433
byp_stq7 10 0 4 9 1 1 1111 0f1e2d3c4b5a69788796a5b4c3d2e1f0 fedcba98765432100123456789abcdef c3d2e1f00f1e2d3c4b5a69788796a5b4
byp_stq8 10 0 0 9 1 0 1111 0f1e2d3c4b5a69788796a5b4c3d2e1f0 fedcba98765432100123456789abcdef fedcba98765432100123456789abcdef
byp_arr_s7 10 0 0 9 0 1 00112233445566778899aabbccddeeff 0f1e2d3c4b5a69788796a5b4c3d2e1f0 fedcba98765432100123456789abcdef 00112233445566778899aabbccddeeff
byp_stq8_le 10 1 6 0 1 0 1111 0f1e2d3c4b5a69788796a5b4c3d2e1f0 fedcba98765432100123456789abcdef efcdab89674523011032547698badcfe

/* tests/tb_load_rotator.sv */
// Load rotator testbench, golden file requests under random input gaps and output back-pressure
`timescale 1ns/1ps

module tb_load_rotator;
   import rot_pkg::*;

   localparam int MAX_TESTS = 64;
   localparam int CLK_HALF  = 20;

   logic      nclk;
   logic      rst;
   logic      in_valid;
   logic      in_ready;
   rot_req_t  in_req;
   logic      out_valid;
   logic      out_ready;
   rot_data_t out_data;
   logic      check_latency;
   int        data_errs;
   int        proto_errs;
   int        out_count;
   int        pending;

   // Golden requests, expected results and names
   rot_req_t    req_mem[MAX_TESTS];
   rot_data_t   exp_mem[MAX_TESTS];
   string       name_mem[MAX_TESTS];
   int          n_tests = 0;
   int          file_errs = 0;
   logic        load_done = 1'b0;
   logic [31:0] lfsr_state = 32'd99816;

   load_rotator_top dut0 (
      .nclk      (nclk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   rot_checker chk0 (
      .nclk          (nclk),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_data      (out_data),
      .check_latency (check_latency),
      .data_errs     (data_errs),
      .proto_errs    (proto_errs),
      .out_count     (out_count),
      .pending       (pending)
   );

   initial begin
      nclk = 1'b0;
      forever #CLK_HALF nclk = ~nclk;
   end

   // --------------------------------------------------
   // Random bits and golden file
   // --------------------------------------------------

   // Galois form, taps 32/22/2/1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end else begin
         return s >> 1;
      end
   endfunction

   function logic next_rand_bit();
      lfsr_state = lfsr_step(lfsr_state);
      return lfsr_state[0];
   endfunction

   task automatic load_golden();
      int           fd;
      int           cnt;
      string        line;
      string        nm;
      logic [4:0]   sz;
      logic         le_v;
      logic [3:0]   be_v;
      logic [3:0]   lesel_v;
      logic         byp_v;
      logic         byp7_v;
      logic [127:0] arr_v;
      logic [127:0] s7_v;
      logic [127:0] s8_v;
      logic [127:0] exp_v;
      fd = $fopen("tests/rot_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open tests/rot_golden.txt");
         file_errs++;
      end else begin
         while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            // Comment lines start with a hash
            if (line.len() == 0 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", nm, sz, le_v, be_v,
                          lesel_v, byp_v, byp7_v, arr_v, s7_v, s8_v, exp_v);
            if (cnt == 11) begin
               name_mem[n_tests]              = nm;
               req_mem[n_tests].size          = rot_size_e'(sz);
               req_mem[n_tests].le            = le_v;
               req_mem[n_tests].be_rotate_sel = be_v;
               req_mem[n_tests].le_rotate_sel = lesel_v;
               req_mem[n_tests].stq_byp_val   = byp_v;
               req_mem[n_tests].stq7_byp_val  = byp7_v;
               req_mem[n_tests].arr_data      = arr_v;
               req_mem[n_tests].stq7_rmw_data = s7_v;
               req_mem[n_tests].stq8_rmw_data = s8_v;
               exp_mem[n_tests]               = exp_v;
               n_tests++;
            end else if (cnt > 0) begin
               $display("Golden file line could not be parsed: %s", line);
               file_errs++;
            end
         end
         $fclose(fd);
         if (n_tests == 0) begin
            $display("Golden file holds no requests");
            file_errs++;
         end
      end
   endtask

   // --------------------------------------------------
   // Request driver, all changes on the falling edge
   // --------------------------------------------------

   task automatic drive_requests(input logic random_mode);
      int   idx;
      logic acc;
      logic gap;
      logic b0;
      logic b1;
      idx = 0;
      acc = 1'b0;
      while (idx < n_tests || in_valid) begin
         @(negedge nclk);
         if (acc) in_valid = 1'b0;
         // Drop out_ready about one cycle in four
         if (random_mode) begin
            b0 = next_rand_bit();
            b1 = next_rand_bit();
            out_ready = ~(b0 & b1);
         end
         if (!in_valid && idx < n_tests) begin
            gap = 1'b0;
            if (random_mode) gap = next_rand_bit();
            if (!gap) begin
               in_req   = req_mem[idx];
               in_valid = 1'b1;
               chk0.add_expect(name_mem[idx], exp_mem[idx]);
               idx++;
            end
         end
         @(posedge nclk);
         acc = in_valid && in_ready;
      end
   endtask

   // Budget scales with both passes over the golden list
   initial begin
      int limit;
      wait (load_done);
      limit = (2 * n_tests * 3 + 50) * 4;
      repeat (limit) @(posedge nclk);
      $display("Timeout after %0d cycles with %0d of %0d outputs received", limit, out_count,
               2 * n_tests);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      int total;
      rst           = 1'b1;
      in_valid      = 1'b0;
      in_req        = '0;
      out_ready     = 1'b1;
      check_latency = 1'b0;
      load_golden();
      load_done = 1'b1;
      repeat (2) @(posedge nclk);
      @(negedge nclk);
      rst = 1'b0;
      // Idle window where out_valid must stay low
      repeat (4) @(negedge nclk);
      check_latency = 1'b1;
      drive_requests(1'b0);
      wait (out_count >= n_tests);
      @(negedge nclk);
      check_latency = 1'b0;
      drive_requests(1'b1);
      @(negedge nclk);
      out_ready = 1'b1;
      wait (out_count >= 2 * n_tests);
      // A few more edges to catch stray outputs
      repeat (8) @(posedge nclk);
      if (pending != 0) begin
         $display("%0d expected outputs never came out of the DUT", pending);
      end
      total = data_errs + proto_errs + pending + file_errs;
      $display("Errors: data %0d, protocol %0d, missing %0d, file %0d", data_errs, proto_errs,
               pending, file_errs);
      if (total == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
